// ==== address_generation.f ====
source/x86_arch_pkg.sv
source/agu_pkg.sv
source/reg_size_select.sv
source/modrm_address.sv
source/string_address.sv
source/operand_select.sv
source/pipe_stage.sv
source/address_generation_top.sv
verif/agu_ref_pkg.sv
verif/address_generation_tb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv verif/*.sv)

.PHONY: run clean

obj_dir/Vaddress_generation_tb: address_generation.f $(SOURCES)
	verilator --binary --timing --assert --top-module address_generation_tb \
		-f address_generation.f -o Vaddress_generation_tb

run: obj_dir/Vaddress_generation_tb
	./obj_dir/Vaddress_generation_tb > run.log 2>&1; cat run.log
	@if grep -q "TB FAILED" run.log; then exit 1; fi
	@grep -q "TB PASSED" run.log

clean:
	rm -rf obj_dir run.log

// ==== verif/address_generation_tb.sv ====
// testbench of the address generation stage, random and directed micro-ops
// per operand class, random back-pressure, hold and flush sequences
module address_generation_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_PER_CLASS = 150;
    localparam int STIM_CYCLES = 4 * (RAND_PER_CLASS + 4) * 2 + 80;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;

    logic clk = 0;
    logic rst_n, flush, r_valid, r_ready, a_valid, a_ready, hold_ready;
    agu_pkg::uop_t r_uop;
    x86_arch_pkg::gpr_file_t r_gpr;
    x86_arch_pkg::seg_file_t r_seg;
    agu_pkg::agu_result_t a_result, exp_head;
    agu_pkg::agu_result_t exp_q[$];
    int exp_count, mismatches, other_errors, cycles;
    logic [31:0] rng_state, ready_state;

    address_generation_top u_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // directed cases for k < 4, random otherwise
    function automatic agu_pkg::uop_t make_uop(int cls, int k);
        agu_pkg::uop_t u;
        logic [191:0] raw;
        raw = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
        u = raw[$bits(agu_pkg::uop_t)-1:0];
        u.size = x86_arch_pkg::reg_size_e'(next_rand() % 5);
        u.op1_kind = agu_pkg::operand_kind_e'(next_rand());
        u.stack_op = 2'(next_rand() % 3);
        case (cls)
            1: u.op0_kind = agu_pkg::OPK_REG;
            2: u.op0_kind = agu_pkg::operand_kind_e'(next_rand());
            3: u.op0_kind = agu_pkg::OPK_MODRM;
            default: u.op0_kind = agu_pkg::OPK_MEM;
        endcase
        if (k < 4) begin
            u.stack_op = 2'b00;
            case (cls)
                1: begin
                    u.op0_reg = 3'(4 + k);
                    u.size = k == 1 ? x86_arch_pkg::SIZE_NONE :
                             k == 2 ? x86_arch_pkg::reg_size_e'(3'd6) : x86_arch_pkg::SIZE_BYTE;
                end
                2: begin
                    u.op0_kind = k == 0 ? agu_pkg::OPK_SYS : k == 1 ? agu_pkg::OPK_NONE :
                                 k == 2 ? agu_pkg::OPK_MMX : agu_pkg::OPK_IMM;
                    u.op1_kind = agu_pkg::OPK_SEG;
                    u.op1_reg = 3'(6 + k);
                end
                3: begin
                    u.modrm = k == 0 ? 8'b00_000_101 : k == 1 ? 8'b01_000_100 :
                              k == 2 ? 8'b10_000_011 : 8'b11_000_110;
                    u.seg_override_valid = (k == 2);
                    u.op1_kind = agu_pkg::OPK_MODRM;
                end
                default: begin
                    u.op1_kind = agu_pkg::OPK_MEM;
                    u.seg_override_valid = k[0];
                    u.stack_op = k == 3 ? 2'b10 : 2'b00;
                end
            endcase
        end
        return u;
    endfunction

    task automatic send(agu_pkg::uop_t u);
        logic ok;
        r_valid = 1'b1;
        r_uop = u;
        for (int i = 0; i < 8; i++) r_gpr[i] = next_rand();
        r_seg = {next_rand(), next_rand(), next_rand()};
        do begin
            @(negedge clk);
            ok = r_ready;
            @(posedge clk);
        end while (!ok);
        #1;
        r_valid = 1'b0;
    endtask

    task automatic set_hold(logic v);
        @(posedge clk);
        #0.5;
        hold_ready = v;
        #0.5;
    endtask

    // stage empty with no input means every accepted micro-op is out
    task automatic drain();
        do begin
            @(negedge clk);
        end while (a_valid);
        if (exp_count != 0) begin
            other_errors++;
            $display("%0d expected results never delivered", exp_count);
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        ready_state = xorshift(ready_state);
        a_ready = hold_ready ? 1'b0 : (ready_state[1:0] != 2'b00);
    end

    // scoreboard queue, expected result of every accepted micro-op
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n || flush) begin
            exp_q.delete();
        end else begin
            if (a_valid && a_ready && exp_q.size() > 0) void'(exp_q.pop_front());
            if (r_valid && r_ready)
                exp_q.push_back(agu_ref_pkg::expect_result(r_uop, r_gpr, r_seg));
        end
        exp_head = exp_q.size() > 0 ? exp_q[0] : '0;
        exp_count = exp_q.size();
    end

    check_op0: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && a_ready |-> a_result.op0 == exp_head.op0)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t a_result.op0 got=%h expected=%h", $time,
                     $sampled(a_result.op0), $sampled(exp_head.op0));
        end
    check_op1: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && a_ready |-> a_result.op1 == exp_head.op1)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t a_result.op1 got=%h expected=%h", $time,
                     $sampled(a_result.op1), $sampled(exp_head.op1));
        end
    check_all: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && a_ready |-> a_result == exp_head)
        else begin
            mismatches++;
            $display("MISMATCH time=%0t a_result got=%h expected=%h", $time,
                     $sampled(a_result), $sampled(exp_head));
        end
    check_expected: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && a_ready |-> exp_count > 0)
        else begin
            other_errors++;
            $display("result delivered with no micro-op outstanding at %0t", $time);
        end
    check_hold: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && !a_ready && !flush |=> a_valid && $stable(a_result))
        else begin
            other_errors++;
            $display("held result changed or vanished under back-pressure at %0t", $time);
        end
    check_stall: assert property (@(posedge clk) disable iff (!rst_n)
        a_valid && !a_ready |-> !r_ready)
        else begin
            other_errors++;
            $display("r_ready high while a full stage is stalled at %0t", $time);
        end
    check_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !a_valid)
        else begin
            other_errors++;
            $display("a_valid still high after a flush at %0t", $time);
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: mismatches=%0d other=%0d", mismatches, other_errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        rng_state = 32'd98;
        ready_state = xorshift(32'd98 ^ 32'h5a5a_1234);
        {rst_n, flush, r_valid, hold_ready, a_ready} = 5'b00001;
        {r_uop, r_gpr, r_seg} = '0;
        {mismatches, other_errors, cycles, exp_count} = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (a_valid !== 1'b0) begin
            other_errors++;
            $display("a_valid not low after reset");
        end
        for (int cls = 1; cls <= 4; cls++) begin
            for (int k = 0; k < RAND_PER_CLASS + 4; k++) send(make_uop(cls, k));
        end
        // stall with a second micro-op waiting, then release
        drain();
        set_hold(1'b1);
        send(make_uop(3, 9));
        fork
            send(make_uop(4, 9));
            begin
                repeat (6) @(posedge clk);
                #0.5;
                hold_ready = 1'b0;
            end
        join
        // flush drops the held result
        drain();
        set_hold(1'b1);
        send(make_uop(1, 9));
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        set_hold(1'b0);
        drain();
        $display("errors: mismatches=%0d other=%0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/agu_ref_pkg.sv ====
// expected results of the address generation stage, built from the
// architectural rules: sized registers, seg*16+offset, string and stack operands
package agu_ref_pkg;

    function automatic logic [31:0] sized_reg(x86_arch_pkg::reg_size_e size,
                                              x86_arch_pkg::gpr_file_t gpr, logic [2:0] idx);
        case (size)
            x86_arch_pkg::SIZE_BYTE:
                return idx[2] ? {24'd0, gpr[idx[1:0]][15:8]} : {24'd0, gpr[idx[1:0]][7:0]};
            x86_arch_pkg::SIZE_WORD:  return {16'd0, gpr[idx][15:0]};
            x86_arch_pkg::SIZE_DWORD: return gpr[idx];
            default:                  return 32'd0;
        endcase
    endfunction

    function automatic logic [15:0] segment_of(x86_arch_pkg::seg_file_t seg, logic [2:0] code);
        case (code)
            3'd0:    return seg.es;
            3'd1:    return seg.cs;
            3'd2:    return seg.ss;
            3'd3:    return seg.ds;
            3'd4:    return seg.fs;
            3'd5:    return seg.gs;
            default: return 16'd0;
        endcase
    endfunction

    function automatic logic [31:0] linear(logic [15:0] s, logic [31:0] off);
        return {12'd0, s, 4'd0} + off;
    endfunction

    function automatic agu_pkg::operand_t operand_value(agu_pkg::operand_kind_e kind,
            logic [2:0] idx, agu_pkg::uop_t u, x86_arch_pkg::gpr_file_t gpr,
            x86_arch_pkg::seg_file_t seg, logic [31:0] mem);
        agu_pkg::operand_t o;
        logic [31:0] off;
        logic [2:0] sc;
        o = '0;
        off = gpr[u.modrm[2:0]] + ((u.modrm[7:6] == 2'b01 || u.modrm[7:6] == 2'b10) ? u.disp : 0);
        sc = u.seg_override_valid ? u.seg_override : (u.modrm[2:1] == 2'b10 ? 3'd2 : 3'd3);
        case (kind)
            agu_pkg::OPK_REG: begin
                o.value  = sized_reg(u.size, gpr, idx);
                o.is_reg = 1'b1;
            end
            agu_pkg::OPK_SEG: begin
                o.value      = {16'd0, segment_of(seg, idx)};
                o.is_segment = 1'b1;
            end
            agu_pkg::OPK_MODRM: begin
                if (u.modrm[7:6] == 2'b11) begin
                    o.value  = sized_reg(u.size, gpr, u.modrm[2:0]);
                    o.is_reg = 1'b1;
                end else begin
                    o.value      = linear(segment_of(seg, sc), off);
                    o.is_address = 1'b1;
                end
            end
            agu_pkg::OPK_IMM: o.value = u.imm;
            agu_pkg::OPK_MEM: begin
                o.value      = mem;
                o.is_address = 1'b1;
            end
            default: o = '0;
        endcase
        return o;
    endfunction

    function automatic agu_pkg::agu_result_t expect_result(agu_pkg::uop_t u,
            x86_arch_pkg::gpr_file_t gpr, x86_arch_pkg::seg_file_t seg);
        agu_pkg::agu_result_t r;
        logic [15:0] src_seg;
        src_seg = u.seg_override_valid ? segment_of(seg, u.seg_override) : seg.ds;
        r = '0;
        r.op0 = operand_value(u.op0_kind, u.op0_reg, u, gpr, seg, linear(seg.es, gpr[7]));
        r.op1 = operand_value(u.op1_kind, u.op1_reg, u, gpr, seg, linear(src_seg, gpr[6]));
        // pop reads from the stack
        if (u.stack_op[1]) begin
            r.op1 = '0;
            r.op1.value      = u.stack_address;
            r.op1.is_address = 1'b1;
        end
        r.op0_reg = u.op0_reg;
        r.op1_reg = u.op1_reg;
        r.imm = u.imm;
        r.size = u.size;
        r.alu_op = u.alu_op;
        r.stack_op = u.stack_op;
        r.stack_address = u.stack_address;
        r.pc = u.pc;
        r.opcode = u.opcode;
        r.to_sys_controller = (u.op0_kind == agu_pkg::OPK_SYS);
        return r;
    endfunction

endpackage

// ==== source/address_generation_top.sv ====
// address generation stage between register read and memory access
// operands are formed combinationally and registered one cycle later
// no SIB, no segment limit checks, no MMX operands
module address_generation_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  logic                      r_valid,
    output logic                      r_ready,
    input  agu_pkg::uop_t             r_uop,
    input  x86_arch_pkg::gpr_file_t   r_gpr,
    input  x86_arch_pkg::seg_file_t   r_seg,
    output logic                      a_valid,
    input  logic                      a_ready,
    output agu_pkg::agu_result_t      a_result
);

    x86_arch_pkg::gpr_file_t         sized;
    logic [x86_arch_pkg::ADDR_W-1:0] op0_modrm_value;
    logic                            op0_modrm_is_address;
    logic [x86_arch_pkg::ADDR_W-1:0] op1_modrm_value;
    logic                            op1_modrm_is_address;
    logic [x86_arch_pkg::ADDR_W-1:0] dest_address;
    logic [x86_arch_pkg::ADDR_W-1:0] src_address;
    agu_pkg::operand_t               op0;
    agu_pkg::operand_t               op1_gen;
    agu_pkg::operand_t               op1;
    agu_pkg::agu_result_t            stage_in;

    reg_size_select u_size_sel (
        .size  (r_uop.size),
        .gpr   (r_gpr),
        .sized (sized)
    );

    modrm_address u_op0_modrm (
        .modrm              (r_uop.modrm),
        .disp               (r_uop.disp),
        .seg_override       (r_uop.seg_override),
        .seg_override_valid (r_uop.seg_override_valid),
        .gpr                (r_gpr),
        .sized              (sized),
        .seg                (r_seg),
        .value              (op0_modrm_value),
        .is_address         (op0_modrm_is_address)
    );

    modrm_address u_op1_modrm (
        .modrm              (r_uop.modrm),
        .disp               (r_uop.disp),
        .seg_override       (r_uop.seg_override),
        .seg_override_valid (r_uop.seg_override_valid),
        .gpr                (r_gpr),
        .sized              (sized),
        .seg                (r_seg),
        .value              (op1_modrm_value),
        .is_address         (op1_modrm_is_address)
    );

    string_address u_string (
        .gpr                (r_gpr),
        .seg                (r_seg),
        .seg_override       (r_uop.seg_override),
        .seg_override_valid (r_uop.seg_override_valid),
        .dest_address       (dest_address),
        .src_address        (src_address)
    );

    // op0 takes the string destination, op1 the string source
    operand_select u_op0_sel (
        .kind             (r_uop.op0_kind),
        .reg_index        (r_uop.op0_reg),
        .modrm            (r_uop.modrm),
        .sized            (sized),
        .seg              (r_seg),
        .imm              (r_uop.imm),
        .modrm_value      (op0_modrm_value),
        .modrm_is_address (op0_modrm_is_address),
        .mem_address      (dest_address),
        .operand          (op0)
    );

    operand_select u_op1_sel (
        .kind             (r_uop.op1_kind),
        .reg_index        (r_uop.op1_reg),
        .modrm            (r_uop.modrm),
        .sized            (sized),
        .seg              (r_seg),
        .imm              (r_uop.imm),
        .modrm_value      (op1_modrm_value),
        .modrm_is_address (op1_modrm_is_address),
        .mem_address      (src_address),
        .operand          (op1)
    );

    // a pop reads its operand from the stack
    always_comb begin
        op1_gen = op1;
        if (r_uop.stack_op[1]) begin
            op1_gen.value      = agu_pkg::OPERAND_W'(r_uop.stack_address);
            op1_gen.is_reg     = 1'b0;
            op1_gen.is_address = 1'b1;
            op1_gen.is_segment = 1'b0;
        end
    end

    always_comb begin
        stage_in.op0               = op0;
        stage_in.op1               = op1_gen;
        stage_in.op0_reg           = r_uop.op0_reg;
        stage_in.op1_reg           = r_uop.op1_reg;
        stage_in.imm               = r_uop.imm;
        stage_in.size              = r_uop.size;
        stage_in.alu_op            = r_uop.alu_op;
        stage_in.stack_op          = r_uop.stack_op;
        stage_in.stack_address     = r_uop.stack_address;
        stage_in.pc                = r_uop.pc;
        stage_in.opcode            = r_uop.opcode;
        stage_in.to_sys_controller = (r_uop.op0_kind == agu_pkg::OPK_SYS);
    end

    pipe_stage u_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (r_valid),
        .in_ready  (r_ready),
        .in_data   (stage_in),
        .out_valid (a_valid),
        .out_ready (a_ready),
        .out_data  (a_result)
    );

endmodule

// ==== source/pipe_stage.sv ====
// single-entry valid/ready register, full throughput while out_ready is high
// flush drops the held entry and anything accepted on the same edge
module pipe_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  agu_pkg::agu_result_t in_data,
    output logic                 out_valid,
    input  logic                 out_ready,
    output agu_pkg::agu_result_t out_data
);

    // can take a new entry when empty or when the current one leaves
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // payload only loads on a transfer, holds under back-pressure
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== source/operand_select.sv ====
// one operand path: value and type flags chosen by the operand kind
// segment operands use reg_index as a seg_id_e code, 6 and 7 read zero
// MMX and SYS kinds carry no value in this stage
module operand_select (
    input  agu_pkg::operand_kind_e          kind,
    input  logic [2:0]                      reg_index,
    input  logic [7:0]                      modrm,
    input  x86_arch_pkg::gpr_file_t         sized,
    input  x86_arch_pkg::seg_file_t         seg,
    input  logic [agu_pkg::IMM_W-1:0]       imm,
    input  logic [x86_arch_pkg::ADDR_W-1:0] modrm_value,
    input  logic                            modrm_is_address,
    input  logic [x86_arch_pkg::ADDR_W-1:0] mem_address,
    output agu_pkg::operand_t               operand
);

    logic [x86_arch_pkg::SEG_W-1:0] seg_sel;
    logic                           modrm_is_reg;

    assign seg_sel = x86_arch_pkg::seg_value(seg, x86_arch_pkg::seg_id_e'(reg_index));

    // register form of mod r/m
    assign modrm_is_reg = (modrm[7:6] == 2'b11);

    always_comb begin
        operand = '0;
        case (kind)
            agu_pkg::OPK_REG: begin
                operand.value  = agu_pkg::OPERAND_W'(sized[reg_index]);
                operand.is_reg = 1'b1;
            end
            agu_pkg::OPK_SEG: begin
                operand.value      = agu_pkg::OPERAND_W'(seg_sel);
                operand.is_segment = 1'b1;
            end
            agu_pkg::OPK_MODRM: begin
                operand.value      = agu_pkg::OPERAND_W'(modrm_value);
                operand.is_reg     = modrm_is_reg;
                operand.is_address = modrm_is_address;
            end
            agu_pkg::OPK_IMM: begin
                operand.value = agu_pkg::OPERAND_W'(imm);
            end
            agu_pkg::OPK_MEM: begin
                // string operand, already a linear address
                operand.value      = agu_pkg::OPERAND_W'(mem_address);
                operand.is_address = 1'b1;
            end
            default: begin
                // none, MMX and SYS
                operand = '0;
            end
        endcase
    end

endmodule

// ==== source/string_address.sv ====
// memory operands of the string instructions
// destination is always ES:EDI, the override never applies to it
// source is DS:ESI unless a segment override is present
module string_address (
    input  x86_arch_pkg::gpr_file_t         gpr,
    input  x86_arch_pkg::seg_file_t         seg,
    input  x86_arch_pkg::seg_id_e           seg_override,
    input  logic                            seg_override_valid,
    output logic [x86_arch_pkg::ADDR_W-1:0] dest_address,
    output logic [x86_arch_pkg::ADDR_W-1:0] src_address
);

    logic [x86_arch_pkg::SEG_W-1:0] src_seg;

    assign dest_address = x86_arch_pkg::linear_address(seg.es,
                                                       gpr[x86_arch_pkg::GPR_EDI]);

    always_comb begin
        if (seg_override_valid) begin
            src_seg = x86_arch_pkg::seg_value(seg, seg_override);
        end else begin
            src_seg = seg.ds;
        end
    end

    assign src_address = x86_arch_pkg::linear_address(src_seg,
                                                      gpr[x86_arch_pkg::GPR_ESI]);

endmodule

// ==== source/modrm_address.sv ====
// evaluates a mod r/m byte without SIB: rm 100 is plain ESP as base
// mod 11 selects a sized register, other mods form seg:base+disp
// mod 00 never adds the displacement, including rm 101
module modrm_address (
    input  logic [7:0]                      modrm,
    input  logic [x86_arch_pkg::ADDR_W-1:0] disp,
    input  x86_arch_pkg::seg_id_e           seg_override,
    input  logic                            seg_override_valid,
    input  x86_arch_pkg::gpr_file_t         gpr,
    input  x86_arch_pkg::gpr_file_t         sized,
    input  x86_arch_pkg::seg_file_t         seg,
    output logic [x86_arch_pkg::ADDR_W-1:0] value,
    output logic                            is_address
);

    logic [1:0]                      mod_field;
    logic [2:0]                      rm_field;
    logic [x86_arch_pkg::ADDR_W-1:0] offset;
    x86_arch_pkg::seg_id_e           seg_id;
    logic [x86_arch_pkg::ADDR_W-1:0] linear;

    assign mod_field = modrm[7:6];
    assign rm_field  = modrm[2:0];

    // base register is always full width
    always_comb begin
        if (mod_field == 2'b01 || mod_field == 2'b10) begin
            offset = gpr[rm_field] + disp;
        end else begin
            offset = gpr[rm_field];
        end
    end

    // override wins, then stack-relative bases default to SS
    always_comb begin
        if (seg_override_valid) begin
            seg_id = seg_override;
        end else if (rm_field == x86_arch_pkg::GPR_ESP || rm_field == x86_arch_pkg::GPR_EBP) begin
            seg_id = x86_arch_pkg::SS;
        end else begin
            seg_id = x86_arch_pkg::DS;
        end
    end

    assign linear = x86_arch_pkg::linear_address(x86_arch_pkg::seg_value(seg, seg_id), offset);

    always_comb begin
        if (mod_field == 2'b11) begin
            value      = sized[rm_field];
            is_address = 1'b0;
        end else begin
            value      = linear;
            is_address = 1'b1;
        end
    end

endmodule

// ==== source/reg_size_select.sv ====
// general register file masked to the operand size of the micro-op
// byte size maps indices 4..7 to AH, CH, DH, BH; all results zero-extended
// size codes other than byte, word and dword give zero registers
module reg_size_select (
    input  x86_arch_pkg::reg_size_e size,
    input  x86_arch_pkg::gpr_file_t gpr,
    output x86_arch_pkg::gpr_file_t sized
);

    x86_arch_pkg::gpr_file_t byte_regs;
    x86_arch_pkg::gpr_file_t word_regs;

    // AL..BL low, AH..BH from the same four registers
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_regs[i]     = x86_arch_pkg::ADDR_W'(gpr[i][7:0]);
            byte_regs[i + 4] = x86_arch_pkg::ADDR_W'(gpr[i][15:8]);
        end
    end

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            word_regs[i] = x86_arch_pkg::ADDR_W'(gpr[i][15:0]);
        end
    end

    always_comb begin
        case (size)
            x86_arch_pkg::SIZE_BYTE: begin
                sized = byte_regs;
            end
            x86_arch_pkg::SIZE_WORD: begin
                sized = word_regs;
            end
            x86_arch_pkg::SIZE_DWORD: begin
                sized = gpr;
            end
            default: begin
                // SIZE_NONE and unused codes
                sized = '0;
            end
        endcase
    end

endmodule

// ==== source/agu_pkg.sv ====
// micro-op, operand and result types of the address generation stage
// operand values are 32 bits wide, there is no 64-bit MMX path
package agu_pkg;

    localparam int OPERAND_W = 32;
    localparam int IMM_W     = 32;

    // MMX and SYS kinds produce a zero value
    typedef enum logic [2:0] {
        OPK_NONE  = 3'd0,
        OPK_REG   = 3'd1,
        OPK_SEG   = 3'd2,
        OPK_MMX   = 3'd3,
        OPK_MODRM = 3'd4,
        OPK_IMM   = 3'd5,
        OPK_MEM   = 3'd6,
        OPK_SYS   = 3'd7
    } operand_kind_e;

    typedef struct packed {
        x86_arch_pkg::reg_size_e          size;
        operand_kind_e                    op0_kind;
        operand_kind_e                    op1_kind;
        logic [2:0]                       op0_reg;
        logic [2:0]                       op1_reg;
        logic [7:0]                       modrm;
        logic [IMM_W-1:0]                 imm;
        logic [x86_arch_pkg::ADDR_W-1:0]  disp;
        x86_arch_pkg::seg_id_e            seg_override;
        logic                             seg_override_valid;
        logic [3:0]                       alu_op;
        // bit 1 marks a pop
        logic [1:0]                       stack_op;
        logic [x86_arch_pkg::ADDR_W-1:0]  stack_address;
        logic [x86_arch_pkg::ADDR_W-1:0]  pc;
        logic [15:0]                      opcode;
    } uop_t;

    typedef struct packed {
        logic [OPERAND_W-1:0] value;
        logic                 is_reg;
        logic                 is_address;
        logic                 is_segment;
    } operand_t;

    typedef struct packed {
        operand_t                         op0;
        operand_t                         op1;
        logic [2:0]                       op0_reg;
        logic [2:0]                       op1_reg;
        logic [IMM_W-1:0]                 imm;
        x86_arch_pkg::reg_size_e          size;
        logic [3:0]                       alu_op;
        logic [1:0]                       stack_op;
        logic [x86_arch_pkg::ADDR_W-1:0]  stack_address;
        logic [x86_arch_pkg::ADDR_W-1:0]  pc;
        logic [15:0]                      opcode;
        logic                             to_sys_controller;
    } agu_result_t;

endpackage

// ==== source/x86_arch_pkg.sv ====
// architectural state of the x86-style core as seen by the address stage
// only the eight 32-bit general registers and six real-mode segments exist
// linear address = segment * 16 + offset, truncated to 32 bits
package x86_arch_pkg;

    localparam int ADDR_W = 32;
    localparam int SEG_W  = 16;

    // encoding order of the general registers
    localparam logic [2:0] GPR_ESP = 3'd4;
    localparam logic [2:0] GPR_EBP = 3'd5;
    localparam logic [2:0] GPR_ESI = 3'd6;
    localparam logic [2:0] GPR_EDI = 3'd7;

    // index 0 is EAX, index 7 is EDI
    typedef logic [7:0][ADDR_W-1:0] gpr_file_t;

    typedef struct packed {
        logic [SEG_W-1:0] es;
        logic [SEG_W-1:0] cs;
        logic [SEG_W-1:0] ss;
        logic [SEG_W-1:0] ds;
        logic [SEG_W-1:0] fs;
        logic [SEG_W-1:0] gs;
    } seg_file_t;

    // codes 6 and 7 select a zero segment
    typedef enum logic [2:0] {
        ES = 3'd0,
        CS = 3'd1,
        SS = 3'd2,
        DS = 3'd3,
        FS = 3'd4,
        GS = 3'd5
    } seg_id_e;

    typedef enum logic [2:0] {
        SIZE_NONE  = 3'd0,
        SIZE_BYTE  = 3'd1,
        SIZE_WORD  = 3'd2,
        SIZE_DWORD = 3'd3
    } reg_size_e;

    function automatic logic [SEG_W-1:0] seg_value(seg_file_t seg, seg_id_e id);
        case (id)
            ES:      return seg.es;
            CS:      return seg.cs;
            SS:      return seg.ss;
            DS:      return seg.ds;
            FS:      return seg.fs;
            GS:      return seg.gs;
            default: return '0;
        endcase
    endfunction

    // real-mode style translation, carry out of bit 31 is dropped
    function automatic logic [ADDR_W-1:0] linear_address(logic [SEG_W-1:0] seg,
                                                         logic [ADDR_W-1:0] offset);
        return (ADDR_W'(seg) << 4) + offset;
    endfunction

endpackage
